// File: geom_frontend.f
+incdir+dv
rtl/gfx_types_pkg.sv
rtl/scene_pkg.sv
rtl/scene_mem.sv
rtl/frame_driver.sv
rtl/setup_queue.sv
rtl/geom_frontend_top.sv
dv/geom_frontend_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := geom_frontend_tb
FILELIST  := geom_frontend.f

OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard dv/*.svh)
PASS_MSG  := *** PASSED ***

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: dv/scene_model.svh
`ifndef SCENE_MODEL_SVH
`define SCENE_MODEL_SVH

// scene image, mirrors what gets loaded into scene_mem
inst_desc_t m_inst  [INST_DEPTH];
transform_t m_xform [INST_DEPTH];
tri_idx_t   m_tri   [TRI_DEPTH];
vertex_t    m_vert  [VERT_DEPTH];

// expected records in issue order
setup_kind_e exp_kind  [$];
transform_t  exp_xform [$];
vertex_t     exp_v0    [$];
vertex_t     exp_v1    [$];
vertex_t     exp_v2    [$];

function automatic logic [15:0] rand16();
    logic [31:0] r;
    r = $urandom();
    return r[15:0];
endfunction

function automatic transform_t random_xform();
    transform_t xf;
    for (int row = 0; row < XFORM_ROWS; row++) begin
        for (int col = 0; col < XFORM_COLS; col++) begin
            xf[row][col] = rand16();
        end
    end
    return xf;
endfunction

function automatic vertex_t random_vertex();
    vertex_t v;
    v.x = rand16();
    v.y = rand16();
    v.z = rand16();
    return v;
endfunction

// instances 0..n_inst, whole index and vertex memories
function automatic void build_scene(input int n_inst);
    logic [31:0] r;
    for (int i = 0; i <= n_inst; i++) begin
        r = $urandom();
        m_inst[i].vert_base = r[7:0];
        m_inst[i].tri_base  = r[15:8];
        m_inst[i].tri_count = 8'($urandom_range(4, 1));
        m_xform[i]          = random_xform();
    end
    for (int t = 0; t < TRI_DEPTH; t++) begin
        r = $urandom();
        m_tri[t] = {r[7:0], r[15:8], r[23:16]};
    end
    for (int v = 0; v < VERT_DEPTH; v++) begin
        m_vert[v] = random_vertex();
    end
endfunction

function automatic void push_record(input setup_kind_e kind, input transform_t xf,
                                    input vertex_t v0, input vertex_t v1, input vertex_t v2);
    exp_kind.push_back(kind);
    exp_xform.push_back(xf);
    exp_v0.push_back(v0);
    exp_v1.push_back(v1);
    exp_v2.push_back(v2);
endfunction

function automatic void gen_expected(input int n_inst);
    tri_idx_t               idx;
    logic [TRI_ADDR_W-1:0]  ta;
    logic [VERT_ADDR_W-1:0] base;
    vertex_t                zero_v;
    zero_v = '0;
    exp_kind.delete();
    exp_xform.delete();
    exp_v0.delete();
    exp_v1.delete();
    exp_v2.delete();
    // camera first, no vertices
    push_record(SETUP_CAMERA, m_xform[0], zero_v, zero_v, zero_v);
    for (int i = 1; i <= n_inst; i++) begin
        base = m_inst[i].vert_base;
        for (int t = 0; t < int'(m_inst[i].tri_count); t++) begin
            // 8 bit sums, both address spaces wrap at 256
            ta  = m_inst[i].tri_base + TRI_ADDR_W'(t);
            idx = m_tri[ta];
            push_record(SETUP_TRIANGLE, m_xform[i], m_vert[base + idx.i0],
                        m_vert[base + idx.i1], m_vert[base + idx.i2]);
        end
    end
endfunction

`endif

// File: dv/geom_frontend_tb.sv
`timescale 1ns/10ps

module geom_frontend_tb
    import gfx_types_pkg::*;
    import scene_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 2000;
    // setup queue depth inside the DUT
    localparam int QUEUE_DEPTH = 4;

    logic              clk;
    logic              rst;
    logic              load_en;
    mem_region_e       load_region;
    logic [7:0]        load_addr;
    logic [LOAD_W-1:0] load_data;
    logic              draw_start;
    logic [INST_W-1:0] max_inst;
    logic              setup_valid;
    setup_kind_e       setup_kind;
    transform_t        setup_xform;
    vertex_t           setup_v0;
    vertex_t           setup_v1;
    vertex_t           setup_v2;
    logic              setup_ready;
    logic              busy;
    logic              draw_done;

    int total_errors;
    int test_errors;
    int check_count;
    int test_count;
    int failed_tests;
    int frames_run;
    bit timed_out;

    `include "scene_model.svh"

    geom_frontend_top dut0 (
        .clk         (clk),
        .rst         (rst),
        .load_en     (load_en),
        .load_region (load_region),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .draw_start  (draw_start),
        .max_inst    (max_inst),
        .setup_valid (setup_valid),
        .setup_kind  (setup_kind),
        .setup_xform (setup_xform),
        .setup_v0    (setup_v0),
        .setup_v1    (setup_v1),
        .setup_v2    (setup_v2),
        .setup_ready (setup_ready),
        .busy        (busy),
        .draw_done   (draw_done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic void count_error();
        total_errors++;
        test_errors++;
    endfunction

    task automatic check_bit(input string what, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            count_error();
            $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_kind(input string what, input setup_kind_e got, input setup_kind_e exp);
        check_count++;
        if (got !== exp) begin
            count_error();
            $display("[ERROR] %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
        end
    endtask

    task automatic check_xform(input string what, input transform_t got, input transform_t exp);
        check_count++;
        if (got !== exp) begin
            count_error();
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_vertex(input string what, input vertex_t got, input vertex_t exp);
        check_count++;
        if (got !== exp) begin
            count_error();
            $display("[ERROR] %0t: %s is (%h %h %h), expected (%h %h %h)", $time, what,
                     got.x, got.y, got.z, exp.x, exp.y, exp.z);
        end
    endtask

    function automatic void end_test(input string name, input int received, input int expected);
        test_count++;
        if (test_errors != 0) begin
            failed_tests++;
        end
        $display("test %-18s records %0d/%0d  errors %0d  %s", name, received, expected,
                 test_errors, (test_errors == 0) ? "ok" : "bad");
    endfunction

    // consumer ready held low for the first stall cycles of a frame
    function automatic logic next_ready(input int cycle, input int stall_cycles);
        if (cycle < stall_cycles) begin
            return 1'b0;
        end
        return ($urandom_range(99, 0) < 60);
    endfunction

    // called and returns 1 ns after a rising edge
    task automatic load_word(input mem_region_e region, input logic [7:0] addr,
                             input logic [LOAD_W-1:0] data);
        load_en     = 1'b1;
        load_region = region;
        load_addr   = addr;
        load_data   = data;
        @(posedge clk);
        #1;
    endtask

    task automatic load_scene(input int n_inst);
        for (int i = 0; i <= n_inst; i++) begin
            load_word(REGION_INST, 8'(i), LOAD_W'(m_inst[i]));
            load_word(REGION_XFORM, 8'(i), LOAD_W'(m_xform[i]));
        end
        for (int t = 0; t < TRI_DEPTH; t++) begin
            load_word(REGION_TRI, 8'(t), LOAD_W'(m_tri[t]));
        end
        for (int v = 0; v < VERT_DEPTH; v++) begin
            load_word(REGION_VERT, 8'(v), LOAD_W'(m_vert[v]));
        end
        load_en = 1'b0;
    endtask

    task automatic check_reset_idle();
        test_errors = 0;
        repeat (10) begin
            @(negedge clk);
            check_bit("setup_valid after reset", setup_valid, 1'b0);
            check_bit("busy after reset", busy, 1'b0);
            check_bit("draw_done after reset", draw_done, 1'b0);
            @(posedge clk);
            #1;
        end
        end_test("reset_idle", 0, 0);
    endtask

    task automatic run_frame(input string name, input int n_inst, input int stall_cycles);
        int          cycles;
        int          received;
        int          expected;
        bit          done_seen;
        bit          hold_pending;
        setup_kind_e held_kind;
        transform_t  held_xform;
        vertex_t     held_v0;
        vertex_t     held_v1;
        vertex_t     held_v2;

        test_errors = 0;
        build_scene(n_inst);
        load_scene(n_inst);
        gen_expected(n_inst);
        expected = exp_kind.size();
        max_inst = INST_W'(n_inst);

        // still idle with draw_done left over from the previous frame
        @(negedge clk);
        check_bit("setup_valid before start", setup_valid, 1'b0);
        check_bit("busy before start", busy, 1'b0);
        check_bit("draw_done before start", draw_done, frames_run > 0);
        @(posedge clk);
        #1;
        draw_start = 1'b1;
        @(posedge clk);
        #1;
        draw_start  = 1'b0;
        setup_ready = next_ready(0, stall_cycles);

        cycles       = 0;
        received     = 0;
        done_seen    = 1'b0;
        hold_pending = 1'b0;
        while (!(done_seen && received == expected) && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            check_bit("busy xor draw_done", busy ^ draw_done, 1'b1);
            if (done_seen) begin
                check_bit("draw_done held", draw_done, 1'b1);
            end else if (draw_done) begin
                done_seen = 1'b1;
                // anything still owed has to be parked in the queue already
                if (expected - received > QUEUE_DEPTH) begin
                    count_error();
                    $display("[ERROR] %0t: draw_done rose with %0d records outstanding",
                             $time, expected - received);
                end
            end
            if (hold_pending) begin
                check_bit("setup_valid while stalled", setup_valid, 1'b1);
                check_kind("stalled kind", setup_kind, held_kind);
                check_xform("stalled xform", setup_xform, held_xform);
                check_vertex("stalled v0", setup_v0, held_v0);
                check_vertex("stalled v1", setup_v1, held_v1);
                check_vertex("stalled v2", setup_v2, held_v2);
                hold_pending = 1'b0;
            end
            if (setup_valid && setup_ready) begin
                if (received < expected) begin
                    check_kind("kind", setup_kind, exp_kind[received]);
                    check_xform("xform", setup_xform, exp_xform[received]);
                    check_vertex("v0", setup_v0, exp_v0[received]);
                    check_vertex("v1", setup_v1, exp_v1[received]);
                    check_vertex("v2", setup_v2, exp_v2[received]);
                    received++;
                end else begin
                    count_error();
                    $display("[ERROR] %0t: setup record beyond the expected %0d",
                             $time, expected);
                end
            end else if (setup_valid) begin
                hold_pending = 1'b1;
                held_kind    = setup_kind;
                held_xform   = setup_xform;
                held_v0      = setup_v0;
                held_v1      = setup_v1;
                held_v2      = setup_v2;
            end
            @(posedge clk);
            #1;
            cycles++;
            setup_ready = next_ready(cycles, stall_cycles);
        end

        if (cycles >= TIMEOUT_CYCLES) begin
            timed_out = 1'b1;
            count_error();
            $display("timeout: %s got %0d of %0d records, draw_done %b after %0d cycles",
                     name, received, expected, draw_done, TIMEOUT_CYCLES);
        end else begin
            // queue must be empty and done must hold
            setup_ready = 1'b1;
            repeat (8) begin
                @(negedge clk);
                check_bit("setup_valid after frame", setup_valid, 1'b0);
                check_bit("draw_done after frame", draw_done, 1'b1);
                @(posedge clk);
                #1;
            end
            setup_ready = 1'b0;
        end
        frames_run++;
        end_test(name, received, expected);
    endtask

    initial begin
        int n_inst;
        void'($urandom(7792));
        rst          = 1'b1;
        load_en      = 1'b0;
        load_region  = REGION_INST;
        load_addr    = '0;
        load_data    = '0;
        draw_start   = 1'b0;
        max_inst     = '0;
        setup_ready  = 1'b0;
        total_errors = 0;
        test_errors  = 0;
        check_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        frames_run   = 0;
        timed_out    = 1'b0;

        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        check_reset_idle();
        n_inst = $urandom_range(5, 0);
        run_frame("frame_random", n_inst, 0);
        if (!timed_out) begin
            n_inst = $urandom_range(5, 0);
            run_frame("frame_reloaded", n_inst, 0);
        end
        if (!timed_out) begin
            run_frame("frame_camera_only", 0, 0);
        end
        if (!timed_out) begin
            // long consumer stall fills the queue and backs up the driver
            run_frame("frame_full", 5, 60);
        end

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_count, failed_tests, check_count, total_errors);
        if (total_errors == 0 && !timed_out) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: rtl/geom_frontend_top.sv
`timescale 1ns/10ps

module geom_frontend_top
    import gfx_types_pkg::*;
    import scene_pkg::*;
(
    input  logic              clk,
    input  logic              rst,

    // scene load port
    input  logic              load_en,
    input  mem_region_e       load_region,
    input  logic [7:0]        load_addr,
    input  logic [LOAD_W-1:0] load_data,

    input  logic              draw_start,
    input  logic [INST_W-1:0] max_inst,

    // setup records
    output logic              setup_valid,
    output setup_kind_e       setup_kind,
    output transform_t        setup_xform,
    output vertex_t           setup_v0,
    output vertex_t           setup_v1,
    output vertex_t           setup_v2,
    input  logic              setup_ready,

    output logic              busy,
    output logic              draw_done
);

    logic [INST_W-1:0]      inst_rd_addr;
    logic [TRI_ADDR_W-1:0]  tri_rd_addr;
    logic [VERT_ADDR_W-1:0] vert_rd_addr;
    inst_desc_t             inst_desc;
    transform_t             inst_xform;
    tri_idx_t               tri_idx;
    vertex_t                vert_data;

    logic        rec_valid;
    logic        rec_ready;
    setup_kind_e rec_kind;
    transform_t  rec_xform;
    vertex_t     rec_v0;
    vertex_t     rec_v1;
    vertex_t     rec_v2;

    scene_mem u_scene_mem (
        .clk          (clk),
        .rst          (rst),
        .load_en      (load_en),
        .load_region  (load_region),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .inst_rd_addr (inst_rd_addr),
        .tri_rd_addr  (tri_rd_addr),
        .vert_rd_addr (vert_rd_addr),
        .inst_desc    (inst_desc),
        .inst_xform   (inst_xform),
        .tri_idx      (tri_idx),
        .vert_data    (vert_data)
    );

    frame_driver u_frame_driver (
        .clk          (clk),
        .rst          (rst),
        .draw_start   (draw_start),
        .max_inst     (max_inst),
        .inst_rd_addr (inst_rd_addr),
        .tri_rd_addr  (tri_rd_addr),
        .vert_rd_addr (vert_rd_addr),
        .inst_desc    (inst_desc),
        .inst_xform   (inst_xform),
        .tri_idx      (tri_idx),
        .vert_data    (vert_data),
        .rec_valid    (rec_valid),
        .rec_kind     (rec_kind),
        .rec_xform    (rec_xform),
        .rec_v0       (rec_v0),
        .rec_v1       (rec_v1),
        .rec_v2       (rec_v2),
        .rec_ready    (rec_ready),
        .busy         (busy),
        .draw_done    (draw_done)
    );

    setup_queue u_setup_queue (
        .clk         (clk),
        .rst         (rst),
        .rec_valid   (rec_valid),
        .rec_kind    (rec_kind),
        .rec_xform   (rec_xform),
        .rec_v0      (rec_v0),
        .rec_v1      (rec_v1),
        .rec_v2      (rec_v2),
        .rec_ready   (rec_ready),
        .setup_valid (setup_valid),
        .setup_kind  (setup_kind),
        .setup_xform (setup_xform),
        .setup_v0    (setup_v0),
        .setup_v1    (setup_v1),
        .setup_v2    (setup_v2),
        .setup_ready (setup_ready)
    );

endmodule

// File: rtl/setup_queue.sv
`timescale 1ns/10ps

module setup_queue
    import gfx_types_pkg::*;
#(
    parameter int DEPTH = 4
) (
    input  logic        clk,
    input  logic        rst,

    // from the driver
    input  logic        rec_valid,
    input  setup_kind_e rec_kind,
    input  transform_t  rec_xform,
    input  vertex_t     rec_v0,
    input  vertex_t     rec_v1,
    input  vertex_t     rec_v2,
    output logic        rec_ready,

    // to the consumer
    output logic        setup_valid,
    output setup_kind_e setup_kind,
    output transform_t  setup_xform,
    output vertex_t     setup_v0,
    output vertex_t     setup_v1,
    output vertex_t     setup_v2,
    input  logic        setup_ready
);

    setup_kind_e kind_mem  [DEPTH];
    transform_t  xform_mem [DEPTH];
    vertex_t     v0_mem    [DEPTH];
    vertex_t     v1_mem    [DEPTH];
    vertex_t     v2_mem    [DEPTH];

    logic [$clog2(DEPTH)-1:0] wr_ptr;
    logic [$clog2(DEPTH)-1:0] rd_ptr;
    logic [$clog2(DEPTH):0]   count;

    logic push;
    logic pop;

    assign rec_ready   = (count != DEPTH);
    assign setup_valid = (count != '0);
    assign push        = rec_valid && rec_ready;
    assign pop         = setup_valid && setup_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // pointers wrap on their own since DEPTH is a power of two
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            kind_mem[wr_ptr]  <= rec_kind;
            xform_mem[wr_ptr] <= rec_xform;
            v0_mem[wr_ptr]    <= rec_v0;
            v1_mem[wr_ptr]    <= rec_v1;
            v2_mem[wr_ptr]    <= rec_v2;
        end
    end

    // head of the ring is always on the outputs
    assign setup_kind  = kind_mem[rd_ptr];
    assign setup_xform = xform_mem[rd_ptr];
    assign setup_v0    = v0_mem[rd_ptr];
    assign setup_v1    = v1_mem[rd_ptr];
    assign setup_v2    = v2_mem[rd_ptr];

    // a push never lands on the unread head slot
    a_no_push_full: assert property (
        @(posedge clk) disable iff (rst)
        push |-> (wr_ptr != rd_ptr) || (count == '0)
    );

    // a pop only reads a slot that has been written
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (rst)
        pop |-> (wr_ptr != rd_ptr) || (count == DEPTH)
    );

endmodule

// File: rtl/frame_driver.sv
`timescale 1ns/10ps

module frame_driver
    import gfx_types_pkg::*;
    import scene_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   draw_start,
    input  logic [INST_W-1:0]      max_inst,

    // scene memory
    output logic [INST_W-1:0]      inst_rd_addr,
    output logic [TRI_ADDR_W-1:0]  tri_rd_addr,
    output logic [VERT_ADDR_W-1:0] vert_rd_addr,
    input  inst_desc_t             inst_desc,
    input  transform_t             inst_xform,
    input  tri_idx_t               tri_idx,
    input  vertex_t                vert_data,

    // setup record out
    output logic                   rec_valid,
    output setup_kind_e            rec_kind,
    output transform_t             rec_xform,
    output vertex_t                rec_v0,
    output vertex_t                rec_v1,
    output vertex_t                rec_v2,
    input  logic                   rec_ready,

    output logic                   busy,
    output logic                   draw_done
);

    typedef enum logic [3:0] {
        IDLE,
        LOAD_INST,
        CAPTURE_INST,
        REQUEST_TRI,
        CAPTURE_IDX,
        REQUEST_V1,
        REQUEST_V2,
        CAPTURE_V2,
        OUTPUT_REC,
        DONE
    } state_e;

    state_e            state;
    logic [INST_W-1:0] inst_id;
    logic [7:0]        tri_ctr;

    // captured payload
    inst_desc_t desc_r;
    transform_t xform_r;
    tri_idx_t   idx_r;
    vertex_t    v0_r;
    vertex_t    v1_r;
    vertex_t    v2_r;

    logic last_tri;
    logic last_inst;

    assign last_tri  = (tri_ctr == desc_r.tri_count - 8'd1);
    assign last_inst = (inst_id == max_inst);

    // memory addresses straight from the walk registers
    assign inst_rd_addr = inst_id;
    assign tri_rd_addr  = desc_r.tri_base + tri_ctr;

    always_comb begin
        case (state)
            // v0 goes out with the freshly read indices
            CAPTURE_IDX: vert_rd_addr = desc_r.vert_base + tri_idx.i0;
            REQUEST_V1:  vert_rd_addr = desc_r.vert_base + idx_r.i1;
            REQUEST_V2:  vert_rd_addr = desc_r.vert_base + idx_r.i2;
            default:     vert_rd_addr = desc_r.vert_base + idx_r.i0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            inst_id   <= '0;
            tri_ctr   <= '0;
            draw_done <= 1'b0;
        end else begin
            case (state)
                IDLE, DONE: begin
                    if (draw_start) begin
                        inst_id   <= '0;
                        draw_done <= 1'b0;
                        state     <= LOAD_INST;
                    end
                end
                LOAD_INST: begin
                    state <= CAPTURE_INST;
                end
                CAPTURE_INST: begin
                    tri_ctr <= '0;
                    // camera has no triangles
                    if (inst_id == '0) begin
                        state <= OUTPUT_REC;
                    end else begin
                        state <= REQUEST_TRI;
                    end
                end
                REQUEST_TRI: state <= CAPTURE_IDX;
                CAPTURE_IDX: state <= REQUEST_V1;
                REQUEST_V1:  state <= REQUEST_V2;
                REQUEST_V2:  state <= CAPTURE_V2;
                CAPTURE_V2:  state <= OUTPUT_REC;
                OUTPUT_REC: begin
                    if (rec_ready) begin
                        if (inst_id != '0 && !last_tri) begin
                            tri_ctr <= tri_ctr + 8'd1;
                            state   <= REQUEST_TRI;
                        end else if (last_inst) begin
                            draw_done <= 1'b1;
                            state     <= DONE;
                        end else begin
                            inst_id <= inst_id + 1'b1;
                            state   <= LOAD_INST;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            CAPTURE_INST: begin
                desc_r  <= inst_desc;
                xform_r <= inst_xform;
                // camera record carries zero vertices
                v0_r    <= '0;
                v1_r    <= '0;
                v2_r    <= '0;
            end
            CAPTURE_IDX: idx_r <= tri_idx;
            REQUEST_V1:  v0_r  <= vert_data;
            REQUEST_V2:  v1_r  <= vert_data;
            CAPTURE_V2:  v2_r  <= vert_data;
            default: begin
            end
        endcase
    end

    assign busy      = (state != IDLE) && (state != DONE);
    assign rec_valid = (state == OUTPUT_REC);
    assign rec_kind  = (inst_id == '0) ? SETUP_CAMERA : SETUP_TRIANGLE;
    assign rec_xform = xform_r;
    assign rec_v0    = v0_r;
    assign rec_v1    = v1_r;
    assign rec_v2    = v2_r;

    // record holds until the queue takes it
    a_rec_hold: assert property (
        @(posedge clk) disable iff (rst)
        rec_valid && !rec_ready |=> rec_valid
            && $stable({rec_kind, rec_xform, rec_v0, rec_v1, rec_v2})
    );

    a_done_not_busy: assert property (
        @(posedge clk) disable iff (rst)
        !(draw_done && busy)
    );

endmodule

// File: rtl/scene_mem.sv
`timescale 1ns/10ps

module scene_mem
    import gfx_types_pkg::*;
    import scene_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,

    // load port
    input  logic                   load_en,
    input  mem_region_e            load_region,
    input  logic [7:0]             load_addr,
    input  logic [LOAD_W-1:0]      load_data,

    // read addresses from the driver
    input  logic [INST_W-1:0]      inst_rd_addr,
    input  logic [TRI_ADDR_W-1:0]  tri_rd_addr,
    input  logic [VERT_ADDR_W-1:0] vert_rd_addr,

    // registered read data
    output inst_desc_t             inst_desc,
    output transform_t             inst_xform,
    output tri_idx_t               tri_idx,
    output vertex_t                vert_data
);

    inst_desc_t inst_mem  [INST_DEPTH];
    transform_t xform_mem [INST_DEPTH];
    tri_idx_t   tri_mem   [TRI_DEPTH];
    vertex_t    vert_mem  [VERT_DEPTH];

    // load decode, one region per write
    always_ff @(posedge clk) begin
        if (load_en) begin
            case (load_region)
                REGION_INST: begin
                    inst_mem[load_addr[INST_W-1:0]] <=
                        inst_desc_t'(load_data[$bits(inst_desc_t)-1:0]);
                end
                REGION_XFORM: begin
                    xform_mem[load_addr[INST_W-1:0]] <=
                        transform_t'(load_data[$bits(transform_t)-1:0]);
                end
                REGION_TRI: begin
                    tri_mem[load_addr[TRI_ADDR_W-1:0]] <=
                        tri_idx_t'(load_data[$bits(tri_idx_t)-1:0]);
                end
                REGION_VERT: begin
                    vert_mem[load_addr[VERT_ADDR_W-1:0]] <=
                        vertex_t'(load_data[$bits(vertex_t)-1:0]);
                end
                default: begin
                end
            endcase
        end
    end

    // synchronous reads, data one cycle after the address
    always_ff @(posedge clk) begin
        inst_desc  <= inst_mem[inst_rd_addr];
        inst_xform <= xform_mem[inst_rd_addr];
        tri_idx    <= tri_mem[tri_rd_addr];
        vert_data  <= vert_mem[vert_rd_addr];
    end

    // instance table and transforms are only INST_DEPTH deep
    a_inst_load_range: assert property (
        @(posedge clk) disable iff (rst)
        load_en && (load_region == REGION_INST || load_region == REGION_XFORM)
            |-> (load_addr < INST_DEPTH)
    );

endmodule

// File: rtl/scene_pkg.sv
package scene_pkg;

    // memory depths and address widths
    localparam int INST_DEPTH  = 16;
    localparam int INST_W      = 4;
    localparam int TRI_DEPTH   = 256;
    localparam int TRI_ADDR_W  = 8;
    localparam int VERT_DEPTH  = 256;
    localparam int VERT_ADDR_W = 8;

    // vertex index relative to an instance's vertex base
    localparam int VIDX_W = 8;

    // load data bus, widest item is a transform
    localparam int LOAD_W = 192;

    typedef struct packed {
        logic [VIDX_W-1:0] i0;
        logic [VIDX_W-1:0] i1;
        logic [VIDX_W-1:0] i2;
    } tri_idx_t;

    typedef struct packed {
        logic [VERT_ADDR_W-1:0] vert_base;
        logic [TRI_ADDR_W-1:0]  tri_base;
        logic [7:0]             tri_count;
    } inst_desc_t;

    typedef enum logic [1:0] {
        REGION_INST  = 2'd0,
        REGION_XFORM = 2'd1,
        REGION_TRI   = 2'd2,
        REGION_VERT  = 2'd3
    } mem_region_e;

endpackage

// File: rtl/gfx_types_pkg.sv
package gfx_types_pkg;

    // fixed-point coordinate and matrix entry width
    localparam int COORD_W = 16;

    // transform matrix shape, rows by columns
    localparam int XFORM_ROWS = 3;
    localparam int XFORM_COLS = 4;

    // one signed fixed-point value
    typedef logic signed [COORD_W-1:0] coord_t;

    // model-space vertex, 48 bits
    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t z;
    } vertex_t;

    // 3x4 affine matrix, row-major, 192 bits
    typedef coord_t [XFORM_ROWS-1:0][XFORM_COLS-1:0] transform_t;

    // what a setup record describes
    typedef enum logic [0:0] {
        SETUP_CAMERA   = 1'b0,
        SETUP_TRIANGLE = 1'b1
    } setup_kind_e;

endpackage
